//--- hw/regmap_pkg.sv
// register map of one digitizer channel: 32 words of 32 bits
// registers 7 and 9 to 12 are read-only, their stored words stay zero
`default_nettype none
package regmap_pkg;
	localparam int REG_COUNT    = 32;
	localparam int REG_IDX_BITS = 5; // width of a register index
	localparam int DATA_BITS    = 32;

	// register numbers
	localparam int REG_FILL_INIT    = 0;  // first fill number
	localparam int REG_CHAN_TAG     = 1;  // bits 2:0 come from the jumpers
	localparam int REG_MUON_BURSTS  = 2;
	localparam int REG_LASER_BURSTS = 3;
	localparam int REG_PED_BURSTS   = 4;
	localparam int REG_GEN_ADDR     = 5;  // generic register address and control
	localparam int REG_GEN_WDATA    = 6;
	localparam int REG_GEN_RDATA    = 7;  // read-only
	localparam int REG_DELAY_TAP    = 8;
	localparam int REG_TAPS_LO      = 9;  // read-only, lines 0 to 4
	localparam int REG_TAPS_MID     = 10; // read-only, lines 5 to 9
	localparam int REG_TAPS_HI      = 11; // read-only, lines 10 to 14
	localparam int REG_DELAY_STATUS = 12; // read-only, bit 1 busy, bit 0 tap error
	localparam int REG_DDR3_START   = 13; // 14 to 31 are scratch

	// field widths
	localparam int BURST_BITS     = 21;
	localparam int FILL_BITS      = 24;
	localparam int TAP_BITS       = 5;
	localparam int DDR3_ADDR_BITS = 23;
	localparam int CH_ADDR_BITS   = 3;
	localparam int TAPS_PER_WORD  = 5; // 25 bits of taps per read-back word

	// delay line sequencing, in clk cycles
	localparam int DELAY_RESET_CYCLES  = 4;
	localparam int DELAY_SETTLE_CYCLES = 8;

	typedef logic [DATA_BITS-1:0] reg_word_t;
	typedef reg_word_t [REG_COUNT-1:0] reg_file_t;

	// non-zero defaults
	localparam reg_word_t RST_FILL_INIT   = 32'd1;
	localparam reg_word_t RST_MUON_BURSTS = 32'd70000;
	localparam reg_word_t RST_DELAY_TAP   = 32'd14;
	localparam reg_word_t RST_DDR3_START  = 32'hF000_0000; // top nibble set: normal addressing

	function automatic reg_word_t reg_reset_value(input int idx);
		case (idx)
			REG_FILL_INIT:   return RST_FILL_INIT;
			REG_MUON_BURSTS: return RST_MUON_BURSTS;
			REG_DELAY_TAP:   return RST_DELAY_TAP;
			REG_DDR3_START:  return RST_DDR3_START;
			default:         return '0;
		endcase
	endfunction

	// settings for the acquisition machine and the generic register port
	typedef struct packed {
		logic [15:0]               channel_tag;
		logic [BURST_BITS-1:0]     num_muon_bursts;
		logic [BURST_BITS-1:0]     num_laser_bursts;
		logic [BURST_BITS-1:0]     num_ped_bursts;
		logic [DATA_BITS-1:0]      genreg_addr_ctrl;
		logic [DATA_BITS-1:0]      genreg_wr_data;
		logic [TAP_BITS-1:0]       delay_tap;
		logic [DDR3_ADDR_BITS-1:0] fixed_ddr3_start_addr;
		logic                      en_fixed_ddr3_start_addr;
	} acq_config_t;
endpackage
`default_nettype wire

//--- hw/host_pkg.sv
// host command port types; op codes other than the three below are acked and ignored
`default_nettype none
package host_pkg;
	typedef enum logic [1:0] {
		OP_LOAD_NUM = 2'd0, // data becomes the register number
		OP_WRITE    = 2'd1, // write data to the selected register
		OP_READ     = 2'd2  // read the selected register
	} host_op_t;

	typedef struct packed {
		host_op_t    op;
		logic [31:0] data;
	} host_cmd_t;

	typedef struct packed {
		logic [31:0] data;    // read word, zero for load and write
		logic        illegal; // register number above 31
	} host_rsp_t;
endpackage
`default_nettype wire

//--- hw/host_access_ctrl.sv
// four-phase req/ack host port; cmd must hold while req is high
// a number with any bit above bit 4 set blocks strobes and reads back zero
// load and write ack two cycles after req, read three
`default_nettype none
module host_access_ctrl (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire                                  req,
	input  wire host_pkg::host_cmd_t             cmd,
	output logic                                 ack,
	output host_pkg::host_rsp_t                  rsp,
	output logic                                 wr_en,
	output logic                                 rd_en,
	output logic [regmap_pkg::REG_IDX_BITS-1:0] reg_idx,
	output regmap_pkg::reg_word_t               wr_data,
	input  wire regmap_pkg::reg_word_t          rd_data
);
	import host_pkg::*;
	import regmap_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_EXEC, S_RD_WAIT, S_ACK} state_t;

	state_t               state;
	logic [DATA_BITS-1:0] reg_num;  // kept whole so a bad number stays visible
	reg_word_t            rsp_data;
	logic                 illegal;

	assign illegal = |reg_num[DATA_BITS-1:REG_IDX_BITS];
	assign reg_idx = reg_num[REG_IDX_BITS-1:0];
	assign wr_data = cmd.data;

	// strobes last exactly the one exec cycle
	assign wr_en = (state == S_EXEC) && (cmd.op == OP_WRITE) && !illegal;
	assign rd_en = (state == S_EXEC) && (cmd.op == OP_READ) && !illegal;

	assign ack = (state == S_ACK);
	assign rsp = '{data: rsp_data, illegal: illegal}; // illegal tracks the current number

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= S_IDLE;
			reg_num <= '0;
		end else begin
			case (state)
				S_IDLE: if (req) state <= S_EXEC;
				S_EXEC: begin
					if (cmd.op == OP_LOAD_NUM)
						reg_num <= cmd.data;
					state <= (cmd.op == OP_READ) ? S_RD_WAIT : S_ACK; // reads wait for the mux
				end
				S_RD_WAIT: state <= S_ACK;
				S_ACK: if (!req) state <= S_IDLE; // hold ack until the host lets go
				default: state <= S_IDLE;
			endcase
		end
	end

	// response word, only looked at while ack is high
	always_ff @(posedge clk) begin
		if (state == S_EXEC)
			rsp_data <= '0;
		else if (state == S_RD_WAIT)
			rsp_data <= illegal ? '0 : rd_data; // no strobe went out, so mask stale data
	end
endmodule
`default_nettype wire

//--- hw/config_regs.sv
// writable register words with their reset defaults
// writes to the read-only numbers 7 and 9 to 12 are dropped, those words read zero here
// cfg follows a write at the same edge that updates the word
`default_nettype none
module config_regs (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 wr_en,
	input  wire [regmap_pkg::REG_IDX_BITS-1:0] reg_idx,
	input  wire regmap_pkg::reg_word_t         wr_data,
	input  wire [regmap_pkg::CH_ADDR_BITS-1:0] ch_addr, // channel address jumpers
	output regmap_pkg::reg_file_t              regs,
	output regmap_pkg::acq_config_t            cfg
);
	import regmap_pkg::*;

	// true for numbers the host may change
	function automatic logic writable(input logic [REG_IDX_BITS-1:0] idx);
		case (idx)
			REG_GEN_RDATA,
			REG_TAPS_LO,
			REG_TAPS_MID,
			REG_TAPS_HI,
			REG_DELAY_STATUS: return 1'b0;
			default:          return 1'b1;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= reg_reset_value(i);
		end else if (wr_en && writable(reg_idx)) begin
			regs[reg_idx] <= wr_data;
		end
	end

	always_comb begin
		// low tag bits always come from the jumpers, never from the register
		cfg.channel_tag      = {regs[REG_CHAN_TAG][15:CH_ADDR_BITS], ch_addr};
		cfg.num_muon_bursts  = regs[REG_MUON_BURSTS][BURST_BITS-1:0];
		cfg.num_laser_bursts = regs[REG_LASER_BURSTS][BURST_BITS-1:0];
		cfg.num_ped_bursts   = regs[REG_PED_BURSTS][BURST_BITS-1:0];
		cfg.genreg_addr_ctrl = regs[REG_GEN_ADDR];
		cfg.genreg_wr_data   = regs[REG_GEN_WDATA];
		cfg.delay_tap        = regs[REG_DELAY_TAP][TAP_BITS-1:0]; // one tap for all lines

		cfg.fixed_ddr3_start_addr = regs[REG_DDR3_START][DDR3_ADDR_BITS-1:0];
		// top nibble all ones selects the normal start addresses
		cfg.en_fixed_ddr3_start_addr = (regs[REG_DDR3_START][31:28] != 4'hF);
	end
endmodule
`default_nettype wire

//--- hw/readback_mux.sv
// read-back word, registered one cycle after rd_en
// tap words carry five lines each; lines beyond NUM_DELAY_LINES read zero
// NUM_DELAY_LINES must be 1 to 15
`default_nettype none
module readback_mux #(
	parameter int NUM_DELAY_LINES = 13
) (
	input  wire                                             clk,
	input  wire                                             reset,
	input  wire                                             rd_en,
	input  wire [regmap_pkg::REG_IDX_BITS-1:0]             reg_idx,
	input  wire regmap_pkg::reg_file_t                     regs,
	input  wire [regmap_pkg::FILL_BITS-1:0]                fill_num,
	input  wire [regmap_pkg::CH_ADDR_BITS-1:0]             ch_addr,
	input  wire regmap_pkg::reg_word_t                     genreg_rd_data,
	input  wire [NUM_DELAY_LINES*regmap_pkg::TAP_BITS-1:0] cur_taps,
	input  wire                                             tap_error,
	input  wire                                             busy,
	output regmap_pkg::reg_word_t                          rd_data
);
	import regmap_pkg::*;

	localparam int SLICE_BITS = TAPS_PER_WORD * TAP_BITS; // 25
	localparam int TAP_WORDS  = 3;

	logic [TAP_WORDS*SLICE_BITS-1:0] taps_ext; // cur_taps padded to three words

	always_comb begin
		taps_ext = '0;
		taps_ext[NUM_DELAY_LINES*TAP_BITS-1:0] = cur_taps;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_data <= '0;
		end else if (rd_en) begin
			case (reg_idx)
				REG_FILL_INIT: rd_data <= reg_word_t'(fill_num); // live count, not the init value
				REG_CHAN_TAG:  rd_data <= {16'h0000, regs[REG_CHAN_TAG][15:CH_ADDR_BITS], ch_addr};
				REG_MUON_BURSTS,
				REG_LASER_BURSTS,
				REG_PED_BURSTS: rd_data <= reg_word_t'(regs[reg_idx][BURST_BITS-1:0]);
				REG_GEN_RDATA: rd_data <= genreg_rd_data;
				REG_TAPS_LO:   rd_data <= reg_word_t'(taps_ext[0 +: SLICE_BITS]);
				REG_TAPS_MID:  rd_data <= reg_word_t'(taps_ext[SLICE_BITS +: SLICE_BITS]);
				REG_TAPS_HI:   rd_data <= reg_word_t'(taps_ext[2*SLICE_BITS +: SLICE_BITS]);
				REG_DELAY_STATUS: rd_data <= reg_word_t'({busy, tap_error});
				default:       rd_data <= regs[reg_idx]; // plain stored word
			endcase
		end
	end
endmodule
`default_nettype wire

//--- hw/delay_tap_sequencer.sv
// applies a new data-bus delay tap: reset pulse, settle wait, then a check of every line
// a tap change while busy restarts the sequence; the reset default tap counts as a change
`default_nettype none
module delay_tap_sequencer #(
	parameter int NUM_DELAY_LINES = 13
) (
	input  wire                                             clk,
	input  wire                                             reset,
	input  wire [regmap_pkg::TAP_BITS-1:0]                 tap,
	input  wire [NUM_DELAY_LINES*regmap_pkg::TAP_BITS-1:0] cur_taps, // taps the lines report
	output logic                                            delay_data_reset,
	output logic                                            tap_error,
	output logic                                            busy
);
	import regmap_pkg::*;

	localparam int CNT_MAX  = (DELAY_SETTLE_CYCLES > DELAY_RESET_CYCLES) ?
		DELAY_SETTLE_CYCLES : DELAY_RESET_CYCLES;
	localparam int CNT_BITS = $clog2(CNT_MAX);

	typedef enum logic [1:0] {S_IDLE, S_RESET, S_SETTLE} state_t;

	state_t              state;
	logic [CNT_BITS-1:0] cnt;
	logic [TAP_BITS-1:0] applied_tap;
	logic                applied_valid; // clear until the first tap has gone out
	logic                tap_changed;
	logic                mismatch;

	assign tap_changed      = !applied_valid || (tap != applied_tap);
	assign delay_data_reset = (state == S_RESET);
	assign busy             = (state != S_IDLE);

	always_comb begin
		mismatch = 1'b0;
		for (int i = 0; i < NUM_DELAY_LINES; i++)
			mismatch |= (cur_taps[i*TAP_BITS +: TAP_BITS] != applied_tap);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= S_IDLE;
			cnt           <= '0;
			applied_tap   <= '0;
			applied_valid <= 1'b0;
			tap_error     <= 1'b0;
		end else if (tap_changed) begin // start over from any state
			state         <= S_RESET;
			cnt           <= '0;
			applied_tap   <= tap;
			applied_valid <= 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
			case (state)
				S_RESET: if (cnt == CNT_BITS'(DELAY_RESET_CYCLES - 1)) begin
					state <= S_SETTLE;
					cnt   <= '0;
				end
				S_SETTLE: if (cnt == CNT_BITS'(DELAY_SETTLE_CYCLES - 1)) begin
					state     <= S_IDLE;
					tap_error <= mismatch; // result stands until the next check
				end
				default: cnt <= '0; // idle
			endcase
		end
	end
endmodule
`default_nettype wire

//--- hw/fill_counter.sv
// fill number counter, wraps at 24 bits
// a load takes init_value one cycle after the request so a new register 0 is seen
// a pending load wins over fill_done
`default_nettype none
module fill_counter (
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               load,       // reset, cnt_reset or register 0 write
	input  wire [regmap_pkg::FILL_BITS-1:0]  init_value, // register 0
	input  wire                               fill_done,  // one pulse per finished fill
	output logic [regmap_pkg::FILL_BITS-1:0] fill_num
);
	import regmap_pkg::*;

	logic load_q; // register 0 has settled by now

	always_ff @(posedge clk) begin
		if (reset) begin
			load_q   <= 1'b0;
			fill_num <= init_value; // register 0 holds its default during reset
		end else begin
			load_q <= load;
			if (load_q)
				fill_num <= init_value;
			else if (fill_done)
				fill_num <= fill_num + 1'b1;
		end
	end
endmodule
`default_nettype wire

//--- hw/digitizer_regs_top.sv
// slow-control register block of one digitizer channel, all on clk
// NUM_DELAY_LINES is 1 to 15; cur_taps packs 5 bits per line, line 0 lowest
`default_nettype none
module digitizer_regs_top #(
	parameter int NUM_DELAY_LINES = 13
) (
	input  wire                                             clk,
	input  wire                                             reset,
	input  wire                                             req,
	input  wire host_pkg::host_cmd_t                       cmd,
	output logic                                            ack,
	output host_pkg::host_rsp_t                            rsp,
	input  wire                                             fill_done,
	input  wire                                             cnt_reset,
	input  wire [regmap_pkg::CH_ADDR_BITS-1:0]             ch_addr,
	input  wire regmap_pkg::reg_word_t                     genreg_rd_data,
	input  wire [NUM_DELAY_LINES*regmap_pkg::TAP_BITS-1:0] cur_taps,
	output regmap_pkg::acq_config_t                        cfg,
	output logic [regmap_pkg::FILL_BITS-1:0]               fill_num,
	output logic                                            delay_data_reset
);
	import regmap_pkg::*;

	logic                    wr_en;
	logic                    rd_en;
	logic [REG_IDX_BITS-1:0] reg_idx;
	reg_word_t               wr_data;
	reg_word_t               rd_data;
	reg_file_t               regs;
	logic                    tap_error;
	logic                    busy;
	logic                    fill_load;

	// the fill count restarts from register 0 on any of these
	assign fill_load = reset || cnt_reset || (wr_en && (reg_idx == REG_FILL_INIT));

	host_access_ctrl u_host (
		.clk(clk), .reset(reset), .req(req), .cmd(cmd), .ack(ack), .rsp(rsp),
		.wr_en(wr_en), .rd_en(rd_en), .reg_idx(reg_idx), .wr_data(wr_data),
		.rd_data(rd_data)
	);

	config_regs u_regs (
		.clk(clk), .reset(reset), .wr_en(wr_en), .reg_idx(reg_idx),
		.wr_data(wr_data), .ch_addr(ch_addr), .regs(regs), .cfg(cfg)
	);

	readback_mux #(.NUM_DELAY_LINES(NUM_DELAY_LINES)) u_rdbk (
		.clk(clk), .reset(reset), .rd_en(rd_en), .reg_idx(reg_idx), .regs(regs),
		.fill_num(fill_num), .ch_addr(ch_addr), .genreg_rd_data(genreg_rd_data),
		.cur_taps(cur_taps), .tap_error(tap_error), .busy(busy), .rd_data(rd_data)
	);

	delay_tap_sequencer #(.NUM_DELAY_LINES(NUM_DELAY_LINES)) u_delay (
		.clk(clk), .reset(reset), .tap(cfg.delay_tap), .cur_taps(cur_taps),
		.delay_data_reset(delay_data_reset), .tap_error(tap_error), .busy(busy)
	);

	fill_counter u_fill (
		.clk(clk), .reset(reset), .load(fill_load),
		.init_value(regs[REG_FILL_INIT][FILL_BITS-1:0]), // low 24 bits of register 0
		.fill_done(fill_done), .fill_num(fill_num)
	);
endmodule
`default_nettype wire

//--- testbench/tb_digitizer_regs.sv
// directed tests for the register block with 13 delay lines
// the delay-line model copies the tap into all lines when delay_data_reset falls
// inputs change 2 units after the rising edge
`default_nettype none
module tb_digitizer_regs;
	import host_pkg::*;
	import regmap_pkg::*;

	localparam int NUM_LINES = 13;
	localparam int WAIT_MAX  = 100; // cycles per handshake wait

	logic                          clk;
	logic                          reset;
	logic                          req;
	host_cmd_t                     cmd;
	logic                          ack;
	host_rsp_t                     rsp;
	logic                          fill_done;
	logic                          cnt_reset;
	logic [CH_ADDR_BITS-1:0]       ch_addr;
	logic [31:0]                   genreg_rd_data;
	logic [NUM_LINES*TAP_BITS-1:0] cur_taps;
	acq_config_t                   cfg;
	logic [FILL_BITS-1:0]          fill_num;
	logic                          delay_data_reset;

	integer seed;
	int     errors;
	int     checks;
	int     force_line;  // -1 when every line follows the tap
	logic [TAP_BITS-1:0] force_value;
	int     dd_pulses;   // rising edges of delay_data_reset

	digitizer_regs_top #(.NUM_DELAY_LINES(NUM_LINES)) UUT (
		.clk(clk), .reset(reset), .req(req), .cmd(cmd), .ack(ack), .rsp(rsp),
		.fill_done(fill_done), .cnt_reset(cnt_reset), .ch_addr(ch_addr),
		.genreg_rd_data(genreg_rd_data), .cur_taps(cur_taps), .cfg(cfg),
		.fill_num(fill_num), .delay_data_reset(delay_data_reset)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// delay lines take the new tap once their reset is released
	initial begin
		forever begin
			@(negedge delay_data_reset);
			#2;
			for (int i = 0; i < NUM_LINES; i++)
				cur_taps[i*TAP_BITS +: TAP_BITS] = (i == force_line) ? force_value : cfg.delay_tap;
		end
	end

	always @(posedge delay_data_reset) dd_pulses++;

	// last resort if something stalls outside a handshake loop
	initial begin
		#2000000;
		$display("Simulation stopped by the watchdog");
		$display("Errors found");
		$finish;
	end

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s, got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %s finished with %0d new errors", name, errors - err_before);
	endtask

	// one four-phase transfer
	task automatic host_cmd(input host_op_t op, input logic [31:0] data, output host_rsp_t r);
		int n;
		@(posedge clk);
		#2;
		cmd.op   = op;
		cmd.data = data;
		req      = 1'b1;
		n = 0;
		while (!ack && n < WAIT_MAX) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!ack) begin
			errors++;
			$display("Timeout waiting for ack to rise");
		end
		r   = rsp;
		req = 1'b0;
		n = 0;
		while (ack && n < WAIT_MAX) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (ack) begin
			errors++;
			$display("Timeout waiting for ack to fall");
		end
	endtask

	task automatic write_reg(input int idx, input logic [31:0] data);
		host_rsp_t r;
		host_cmd(OP_LOAD_NUM, idx, r);
		host_cmd(OP_WRITE, data, r);
	endtask

	task automatic read_reg(input int idx, output logic [31:0] data);
		host_rsp_t r;
		host_cmd(OP_LOAD_NUM, idx, r);
		host_cmd(OP_READ, 32'h0, r);
		data = r.data;
	endtask

	// polls the status word until busy clears
	task automatic wait_delay_idle(output logic [31:0] status);
		int tries;
		tries = 0;
		read_reg(REG_DELAY_STATUS, status);
		while (status[1] && tries < 50) begin
			read_reg(REG_DELAY_STATUS, status);
			tries++;
		end
		if (status[1]) begin
			errors++;
			$display("Timeout waiting for the delay sequencer to go idle");
		end
	endtask

	// five lines of 5 bits per word, lines past the last one are zero
	function automatic logic [31:0] tap_word(input int w, input logic [4:0] t);
		logic [31:0] e;
		e = '0;
		for (int j = 0; j < 5; j++)
			if (w*5 + j < NUM_LINES)
				e[j*5 +: 5] = t;
		return e;
	endfunction

	task automatic test_reset_defaults();
		int e0;
		logic [31:0] d;
		host_rsp_t r;
		e0 = errors;
		host_cmd(OP_READ, 32'h0, r); // no load yet, so this reads the reset number 0
		check(r.illegal, 0, "illegal flag after reset");
		check(r.data, 32'd1, "read of the reset register number");
		read_reg(REG_FILL_INIT, d);
		check(d, 32'd1, "fill_num after reset");
		read_reg(REG_MUON_BURSTS, d);
		check(d, 32'd70000, "muon bursts default");
		read_reg(REG_DELAY_TAP, d);
		check(d, 32'd14, "delay tap default");
		read_reg(REG_DDR3_START, d);
		check(d, 32'hF000_0000, "ddr3 start default");
		check(cfg.en_fixed_ddr3_start_addr, 0, "fixed ddr3 enable default");
		report_test("reset_defaults", e0);
	endtask

	task automatic test_random_rw();
		int e0;
		logic [31:0] w;
		logic [31:0] d;
		e0 = errors;
		for (int idx = 2; idx < REG_COUNT; idx++) begin
			if (idx == 7 || (idx >= 9 && idx <= 12))
				continue; // read-only numbers
			w = $random(seed);
			write_reg(idx, w);
			read_reg(idx, d);
			check(d, (idx <= 4) ? {11'b0, w[20:0]} : w, $sformatf("reg %0d readback", idx));
			case (idx)
				2: check(cfg.num_muon_bursts, w[20:0], "cfg muon bursts");
				3: check(cfg.num_laser_bursts, w[20:0], "cfg laser bursts");
				4: check(cfg.num_ped_bursts, w[20:0], "cfg pedestal bursts");
				5: check(cfg.genreg_addr_ctrl, w, "cfg generic address");
				6: check(cfg.genreg_wr_data, w, "cfg generic write data");
				8: check(cfg.delay_tap, w[4:0], "cfg delay tap");
				13: begin
					check(cfg.fixed_ddr3_start_addr, w[22:0], "cfg ddr3 start");
					check(cfg.en_fixed_ddr3_start_addr, w[31:28] != 4'hF, "cfg ddr3 enable");
				end
				default: ;
			endcase
		end
		report_test("random_rw", e0);
	endtask

	task automatic test_read_only();
		int e0;
		logic [31:0] w;
		logic [31:0] d;
		e0 = errors;
		genreg_rd_data = $random(seed);
		write_reg(REG_GEN_RDATA, ~genreg_rd_data);
		read_reg(REG_GEN_RDATA, d);
		check(d, genreg_rd_data, "reg 7 follows generic read data");
		w = $random(seed);
		write_reg(REG_CHAN_TAG, w);
		read_reg(REG_CHAN_TAG, d);
		check(d, {16'h0, w[15:3], ch_addr}, "reg 1 readback");
		check(cfg.channel_tag, {w[15:3], ch_addr}, "cfg channel tag");
		report_test("read_only", e0);
	endtask

	task automatic test_illegal_num();
		int e0;
		logic [31:0] a;
		logic [31:0] d;
		host_rsp_t r;
		e0 = errors;
		a = $random(seed);
		write_reg(REG_GEN_WDATA, a);
		host_cmd(OP_LOAD_NUM, 32'h20, r);
		check(r.illegal, 1, "illegal flag on load");
		host_cmd(OP_READ, 32'h0, r);
		check(r.illegal, 1, "illegal flag on read");
		check(r.data, 32'h0, "illegal read data");
		host_cmd(OP_LOAD_NUM, 32'h20 | REG_GEN_WDATA, r); // low bits alias register 6
		host_cmd(OP_WRITE, ~a, r);
		check(r.illegal, 1, "illegal flag on write");
		check(cfg.genreg_wr_data, a, "cfg generic write data after illegal write");
		read_reg(REG_GEN_WDATA, d);
		check(d, a, "reg 6 kept after illegal write");
		report_test("illegal_num", e0);
	endtask

	task automatic test_fill_count();
		int e0;
		logic [31:0] v;
		logic [31:0] d;
		e0 = errors;
		v = $random(seed);
		write_reg(REG_FILL_INIT, v);
		repeat (5) begin
			@(posedge clk);
			#2 fill_done = 1'b1;
			@(posedge clk);
			#2 fill_done = 1'b0;
		end
		check(fill_num, {8'h0, v[23:0] + 24'd5}, "fill_num output after 5 fills");
		read_reg(REG_FILL_INIT, d);
		check(d, {8'h0, v[23:0] + 24'd5}, "fill count after 5 fills");
		@(posedge clk);
		#2 cnt_reset = 1'b1;
		@(posedge clk);
		#2 cnt_reset = 1'b0;
		repeat (2) @(posedge clk); // load lands one cycle late
		read_reg(REG_FILL_INIT, d);
		check(d, {8'h0, v[23:0]}, "fill count after cnt_reset");
		check(fill_num, {8'h0, v[23:0]}, "fill_num output after cnt_reset");
		report_test("fill_count", e0);
	endtask

	task automatic test_delay_tap();
		int e0;
		int p0;
		logic [31:0] d;
		e0 = errors;
		write_reg(REG_DELAY_TAP, 32'd0); // known starting tap
		wait_delay_idle(d);
		p0 = dd_pulses;
		write_reg(REG_DELAY_TAP, 32'd7);
		wait_delay_idle(d);
		check(dd_pulses - p0, 1, "delay_data_reset pulses for tap 7");
		check(d, 32'h0, "delay status after tap 7");
		for (int w = 0; w < 3; w++) begin
			read_reg(REG_TAPS_LO + w, d);
			check(d, tap_word(w, 5'd7), $sformatf("tap word %0d", w));
		end
		force_line  = 3; // one line stuck
		force_value = 5'd9;
		write_reg(REG_DELAY_TAP, 32'd12);
		wait_delay_idle(d);
		check(d, 32'h1, "tap error with a stuck line");
		force_line = -1;
		report_test("delay_tap", e0);
	endtask

	initial begin
		seed           = 48;
		errors         = 0;
		checks         = 0;
		dd_pulses      = 0;
		force_line     = -1;
		force_value    = '0;
		reset          = 1'b1;
		req            = 1'b0;
		cmd            = '0;
		fill_done      = 1'b0;
		cnt_reset      = 1'b0;
		ch_addr        = 3'd5;
		genreg_rd_data = '0;
		cur_taps       = '0;
		repeat (5) @(posedge clk);
		#2 reset = 1'b0;
		test_reset_defaults();
		test_random_rw();
		test_read_only();
		test_illegal_num();
		test_fill_count();
		test_delay_tap();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end
endmodule
`default_nettype wire

//--- list.f
hw/regmap_pkg.sv
hw/host_pkg.sv
hw/host_access_ctrl.sv
hw/config_regs.sv
hw/readback_mux.sv
hw/delay_tap_sequencer.sv
hw/fill_counter.sv
hw/digitizer_regs_top.sv
testbench/tb_digitizer_regs.sv

//--- Bender.yml
package:
  name: digitizer_regs

sources:
  - hw/regmap_pkg.sv
  - hw/host_pkg.sv
  - hw/host_access_ctrl.sv
  - hw/config_regs.sv
  - hw/readback_mux.sv
  - hw/delay_tap_sequencer.sv
  - hw/fill_counter.sv
  - hw/digitizer_regs_top.sv
  - target: test
    files:
      - testbench/tb_digitizer_regs.sv
